//--- bench/sms_io_props.sv
module sms_io_props (
  input logic                          cpuClock,
  input logic                          n_hard_reset,
  input logic                          i_psel,
  input logic                          i_penable,
  input logic                          i_pready,
  input logic [sms_io_pkg::NUM_SLOTS+3:0] i_strobes,
  input logic [sms_io_pkg::DATA_W-1:0]    i_mem_ctrl
);
  import sms_io_pkg::*;

  int unsigned fail_count = 0;  // Read by the testbench at the end

  // Zero wait states
  a_pready_in_access: assert property (@(posedge cpuClock) i_pready == (i_psel && i_penable))
    else begin
      $error("pready does not follow psel and penable");
      fail_count++;
    end

  a_strobe_onehot: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    $onehot0(i_strobes) && (|i_strobes -> i_pready))
    else begin
      $error("decoded strobes overlap or fire outside an access");
      fail_count++;
    end

  a_mem_ctrl_reset: assert property (@(posedge cpuClock)
    !n_hard_reset |=> i_mem_ctrl == MEM_CTRL_RESET)
    else begin
      $error("memory control is not F7 after reset");
      fail_count++;
    end

endmodule

bind apb_io_decoder sms_io_props u_props (
  .cpuClock     (cpuClock),
  .n_hard_reset (n_hard_reset),
  .i_psel       (i_psel),
  .i_penable    (i_penable),
  .i_pready     (o_pready),
  .i_strobes    ({strobe.vdp_data_wr, strobe.vdp_data_rd,
                  strobe.vdp_ctrl_wr, strobe.vdp_ctrl_rd, strobe.slot_wr}),
  .i_mem_ctrl   (mem_ctrl)
);

//--- bench/sms_io_tb.sv
module sms_io_tb;
  import sms_io_pkg::*;

  localparam int NUM_REGS = 11;
  localparam int N_RAND   = 16;
  localparam int ACC      = 4;  // Cycles per access with its compare

  localparam logic [16:0] ADDR_VDP_DATA = 17'h100BE;
  localparam logic [16:0] ADDR_VDP_CTRL = 17'h100BF;
  localparam logic [16:0] ADDR_MEM_CTRL = 17'h1003E;
  localparam logic [16:0] ADDR_JOY_A    = 17'h100DC;
  localparam logic [16:0] ADDR_JOY_B    = 17'h100DD;
  localparam logic [16:0] ADDR_SLOT0    = 17'h0FFFD;

  // Estimated length of each test in cycles
  localparam int LEN_RESET  = 3 + 2 * 4;
  localparam int LEN_PTR    = ACC * (2 + N_RAND);
  localparam int LEN_REGS   = ACC * 2 * (N_RAND + 1);
  localparam int LEN_CRAM   = ACC * 5;
  localparam int LEN_MAPPER = ACC * 4 + 2 * (N_RAND + 1);
  localparam int LEN_STATUS = 2 * 2 + ACC * 6;
  localparam int CYCLE_LIMIT =
    2 * (LEN_RESET + LEN_PTR + LEN_REGS + LEN_CRAM + LEN_MAPPER + LEN_STATUS);

  localparam int OUT_VRAM   = 0;
  localparam int OUT_CRAM   = 1;
  localparam int OUT_MODE   = 2;
  localparam int OUT_NAME   = 3;
  localparam int OUT_SPRITE = 4;
  localparam int OUT_VIDEO  = 5;
  localparam int OUT_XSCR   = 6;
  localparam int OUT_YSCR   = 7;
  localparam int OUT_ROM    = 8;
  localparam int OUT_BIOS   = 9;
  localparam int OUT_RAM    = 10;
  localparam int NUM_OUTS   = 11;
  localparam int EXP_STATUS = 11;
  localparam int EXP_JOY    = 12;

  logic        cpuClock;
  logic        n_hard_reset;
  logic        psel, penable, pwrite;
  logic [16:0] paddr;
  logic [7:0]  pwdata, prdata;
  logic        pready;
  logic [5:0]  buttons;
  logic        frame_int, sprite_collision;
  logic [15:0] cpu_addr;
  logic [21:0] rom_addr;
  logic        bios_sel, ram_sel, cram_sel, video_on;
  logic [13:0] vram_addr, name_table_addr, sprite_attr_addr;
  logic [2:0]  mode;
  logic [7:0]  x_scroll, y_scroll;

  // Reference model state
  logic [7:0]  m_regs [NUM_REGS];
  logic [7:0]  m_first, m_memctrl;
  logic        m_second, m_cram, m_frame, m_coll;
  logic [13:0] m_ptr;
  logic [7:0]  m_banks [3];

  logic [31:0] rng = 32'h1722;
  logic        compare_pending = 1'b0;
  int          cycle_count = 0;
  int          total_checks = 0;
  int          total_errors = 0;
  int          test_errors = 0;
  int          tests_failed = 0;
  int          test_num = 0;
  int          assert_fails;

  sms_io_top #(.NUM_VDP_REGS(NUM_REGS)) UUT (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_psel             (psel),
    .i_penable          (penable),
    .i_pwrite           (pwrite),
    .i_paddr            (paddr),
    .i_pwdata           (pwdata),
    .o_prdata           (prdata),
    .o_pready           (pready),
    .i_buttons          (buttons),
    .i_frame_int        (frame_int),
    .i_sprite_collision (sprite_collision),
    .i_cpu_addr         (cpu_addr),
    .o_rom_addr         (rom_addr),
    .o_bios_sel         (bios_sel),
    .o_ram_sel          (ram_sel),
    .o_vram_addr        (vram_addr),
    .o_cram_sel         (cram_sel),
    .o_mode             (mode),
    .o_name_table_addr  (name_table_addr),
    .o_sprite_attr_addr (sprite_attr_addr),
    .o_video_on         (video_on),
    .o_x_scroll         (x_scroll),
    .o_y_scroll         (y_scroll)
  );

  initial cpuClock = 1'b0;
  always #50 cpuClock = ~cpuClock;

  // Watchdog
  always @(posedge cpuClock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    total_checks++;
    if (got !== exp) begin
      $display("** Error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
      total_errors++;
      test_errors++;
    end
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] ref_output(input int sel);
    logic [1:0] page;
    logic [2:0] exp_mode;
    page = cpu_addr[15:14];
    if (m_regs[0][2]) exp_mode = 3'd4;
    else if (m_regs[1][3]) exp_mode = 3'd3;
    else if (m_regs[0][1]) exp_mode = 3'd2;
    else if (m_regs[1][4]) exp_mode = 3'd1;
    else exp_mode = 3'd0;
    case (sel)
      OUT_VRAM:   return m_ptr;
      OUT_CRAM:   return m_cram;
      OUT_MODE:   return exp_mode;
      OUT_NAME:   return 32'(m_regs[2][3:1]) << 11;
      OUT_SPRITE: return 32'(m_regs[5][6:1]) << 8;
      OUT_VIDEO:  return m_regs[1][6];
      OUT_XSCR:   return m_regs[8];
      OUT_YSCR:   return m_regs[9];
      OUT_ROM:    return (page == 2'd3) ? 32'd0 : (32'(m_banks[page]) << 14) | cpu_addr[13:0];
      OUT_BIOS:   return (page != 2'd3) && !m_memctrl[3];
      OUT_RAM:    return page == 2'd3;
      EXP_STATUS: return {m_frame, 1'b0, m_coll, 5'b11111};
      EXP_JOY:    return {2'b11, ~buttons};  // Pads read active low
      default:    return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] dut_output(input int sel);
    case (sel)
      OUT_VRAM:   return vram_addr;
      OUT_CRAM:   return cram_sel;
      OUT_MODE:   return mode;
      OUT_NAME:   return name_table_addr;
      OUT_SPRITE: return sprite_attr_addr;
      OUT_VIDEO:  return video_on;
      OUT_XSCR:   return x_scroll;
      OUT_YSCR:   return y_scroll;
      OUT_ROM:    return rom_addr;
      OUT_BIOS:   return bios_sel;
      default:    return ram_sel;
    endcase
  endfunction

  function automatic string out_name(input int sel);
    case (sel)
      OUT_VRAM:   return "o_vram_addr";
      OUT_CRAM:   return "o_cram_sel";
      OUT_MODE:   return "o_mode";
      OUT_NAME:   return "o_name_table_addr";
      OUT_SPRITE: return "o_sprite_attr_addr";
      OUT_VIDEO:  return "o_video_on";
      OUT_XSCR:   return "o_x_scroll";
      OUT_YSCR:   return "o_y_scroll";
      OUT_ROM:    return "o_rom_addr";
      OUT_BIOS:   return "o_bios_sel";
      default:    return "o_ram_sel";
    endcase
  endfunction

  task automatic reset_model();
    for (int r = 0; r < NUM_REGS; r++) begin
      m_regs[r] = 8'h00;
    end
    for (int s = 0; s < 3; s++) begin
      m_banks[s] = 8'(s);
    end
    m_first   = 8'h00;
    m_memctrl = 8'hF7;
    m_second  = 1'b0;
    m_cram    = 1'b0;
    m_frame   = 1'b0;
    m_coll    = 1'b0;
    m_ptr     = '0;
  endtask

  task automatic model_ctrl_write(input logic [7:0] data);
    if (!m_second) begin
      m_first  = data;
      m_second = 1'b1;
    end else begin
      m_second = 1'b0;
      if (data[7:6] < 2'd2) begin
        m_ptr  = {data[5:0], m_first};
        m_cram = 1'b0;
      end else if (data[7:6] == 2'd2 && data[3:0] < NUM_REGS) begin
        m_regs[data[3:0]] = m_first;
      end else begin
        m_ptr  = {8'h00, m_first[5:0]};  // CRAM entry or bad index
        m_cram = 1'b1;
      end
    end
  endtask

  // Compares every output once stable
  always @(negedge cpuClock) begin
    if (compare_pending) begin
      for (int s = 0; s < NUM_OUTS; s++) begin
        if (s != OUT_ROM || cpu_addr[15:14] != 2'b11) begin
          check_value(out_name(s), dut_output(s), ref_output(s));
        end
      end
      compare_pending = 1'b0;
    end
  end

  task automatic compare_now();
    compare_pending = 1'b1;
    wait (!compare_pending);
  endtask

  // ==================================================
  // APB access
  // ==================================================
  task automatic drive_write(input logic [16:0] addr, input logic [7:0] data);
    @(posedge cpuClock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(negedge cpuClock);
    check_value("o_pready", pready, 32'd0);  // Setup phase
    @(posedge cpuClock);
    penable <= 1'b1;
    @(negedge cpuClock);
    check_value("o_pready", pready, 32'd1);
    @(posedge cpuClock);  // Write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic drive_read(input logic [16:0] addr, output logic [7:0] data);
    @(posedge cpuClock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(negedge cpuClock);
    check_value("o_pready", pready, 32'd0);  // Setup phase
    @(posedge cpuClock);
    penable <= 1'b1;
    @(negedge cpuClock);
    check_value("o_pready", pready, 32'd1);
    data = prdata;
    @(posedge cpuClock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic ctrl_write(input logic [7:0] data);
    drive_write(ADDR_VDP_CTRL, data);
    model_ctrl_write(data);
    compare_now();
  endtask

  task automatic data_access(input logic do_write);
    logic [7:0] got;
    if (do_write) begin
      drive_write(ADDR_VDP_DATA, 8'(xorshift()));
    end else begin
      drive_read(ADDR_VDP_DATA, got);
      check_value("o_prdata", got, 32'h00);
    end
    m_ptr    = m_ptr + 1'b1;
    m_second = 1'b0;
    compare_now();
  endtask

  task automatic status_read();
    logic [7:0] got;
    drive_read(ADDR_VDP_CTRL, got);
    check_value("o_prdata", got, ref_output(EXP_STATUS));
    m_frame  = 1'b0;
    m_coll   = 1'b0;
    m_second = 1'b0;
    compare_now();
  endtask

  task automatic set_cpu_addr(input logic [15:0] addr);
    @(posedge cpuClock);
    cpu_addr <= addr;
    compare_now();
  endtask

  task automatic pulse_flag(input logic frame);
    @(posedge cpuClock);
    frame_int        <= frame;
    sprite_collision <= !frame;
    @(posedge cpuClock);
    frame_int        <= 1'b0;
    sprite_collision <= 1'b0;
    if (frame) m_frame = 1'b1;
    else m_coll = 1'b1;
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      $display("Test %0d (%s): ok", test_num, name);
    end else begin
      $display("Test %0d (%s): %0d mismatches", test_num, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    logic [7:0] got;
    logic [7:0] first;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    buttons = '0;
    frame_int = 1'b0;
    sprite_collision = 1'b0;
    cpu_addr = '0;
    n_hard_reset = 1'b0;
    reset_model();
    repeat (3) @(posedge cpuClock);
    n_hard_reset <= 1'b1;

    compare_now();
    for (int p = 1; p < 3; p++) begin
      set_cpu_addr(16'(p) << 14);
    end
    set_cpu_addr(16'h0000);
    finish_test("reset values");

    ctrl_write(8'(xorshift()));
    ctrl_write({2'b01, 6'(xorshift())});
    for (int i = 0; i < N_RAND; i++) begin
      data_access(xorshift() & 1);
    end
    finish_test("pointer auto-increment");

    for (int i = 0; i < N_RAND; i++) begin
      ctrl_write(8'(xorshift()));
      ctrl_write({2'b10, 2'(xorshift()), 4'(xorshift() % NUM_REGS)});
    end
    ctrl_write(8'(xorshift()));
    ctrl_write({4'b1000, 4'(NUM_REGS + xorshift() % 5)});  // Out of range index
    finish_test("register writes");

    first = 8'(xorshift());
    ctrl_write(first);
    ctrl_write({2'b11, 6'(xorshift())});
    data_access(1'b1);
    ctrl_write(8'(xorshift()));
    ctrl_write({2'b00, 6'(xorshift())});
    finish_test("CRAM select");

    for (int s = 0; s < 3; s++) begin
      m_banks[s] = 8'(xorshift());
      drive_write(ADDR_SLOT0 + 17'(s), m_banks[s]);
      compare_now();
    end
    m_memctrl = 8'(xorshift()) | 8'h08;  // BIOS off
    drive_write(ADDR_MEM_CTRL, m_memctrl);
    compare_now();
    for (int i = 0; i < N_RAND; i++) begin
      set_cpu_addr(16'(xorshift()));
    end
    set_cpu_addr(16'hC000 | 16'(xorshift() & 32'h3FFF));
    finish_test("mapper");

    pulse_flag(1'b1);
    status_read();
    status_read();
    pulse_flag(1'b0);
    status_read();
    status_read();
    @(posedge cpuClock);
    buttons <= 6'(xorshift());
    drive_read(ADDR_JOY_A, got);
    check_value("o_prdata", got, ref_output(EXP_JOY));
    drive_read(ADDR_JOY_B, got);
    check_value("o_prdata", got, ref_output(EXP_JOY));
    finish_test("status and joypad");

    assert_fails = UUT.u_decoder.u_props.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             test_num, tests_failed, total_checks, total_errors, assert_fails);
    if (total_errors == 0 && tests_failed == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/apb_io_decoder.sv
module apb_io_decoder (
  input  logic                              cpuClock,
  input  logic                              n_hard_reset,
  input  logic                              i_psel,
  input  logic                              i_penable,
  input  logic                              i_pwrite,
  input  logic [sms_io_pkg::APB_ADDR_W-1:0] i_paddr,
  input  logic [sms_io_pkg::DATA_W-1:0]     i_pwdata,
  output logic [sms_io_pkg::DATA_W-1:0]     o_prdata,
  output logic                              o_pready,
  input  logic [sms_io_pkg::BUTTON_W-1:0]   i_buttons,
  input  logic [sms_io_pkg::DATA_W-1:0]     i_status,
  input  logic [sms_io_pkg::DATA_W-1:0]     i_vdp_rd_data,
  output logic                              o_bios_enable,
  io_strobe_if.source                       strobe
);
  import sms_io_pkg::*;

  logic                 access;
  logic                 io_space;
  logic [1:0]           port;
  logic                 odd_port;
  logic                 io_wr, io_rd, mem_wr;
  logic                 vdp_data_sel, vdp_ctrl_sel, joy_sel, mem_ctrl_sel;
  logic [NUM_SLOTS-1:0] slot_wr;
  logic [DATA_W-1:0]    mem_ctrl;
  logic [DATA_W-1:0]    joy_data;

  assign access   = i_psel && i_penable;  // No wait states
  assign o_pready = access;
  assign io_space = i_paddr[APB_ADDR_W-1];
  assign port     = i_paddr[7:6];
  assign odd_port = i_paddr[0];

  assign io_wr  = access && io_space && i_pwrite;
  assign io_rd  = access && io_space && !i_pwrite;
  assign mem_wr = access && !io_space && i_pwrite;

  // ==================================================
  // Port decode
  // ==================================================
  assign vdp_data_sel = (port == PORT_VDP_DATA) && !odd_port;
  assign vdp_ctrl_sel = (port == PORT_VDP_CTRL) && odd_port;
  assign mem_ctrl_sel = (port == PORT_MEM_CTRL) && !odd_port;
  assign joy_sel      = (port == PORT_JOY);  // Both pads read the same buttons

  assign strobe.vdp_data_wr = io_wr && vdp_data_sel;
  assign strobe.vdp_data_rd = io_rd && vdp_data_sel;
  assign strobe.vdp_ctrl_wr = io_wr && vdp_ctrl_sel;
  assign strobe.vdp_ctrl_rd = io_rd && vdp_ctrl_sel;
  assign strobe.wdata       = i_pwdata;

  // Bank registers live at the top of memory space
  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      slot_wr[i] = mem_wr && (i_paddr[CPU_ADDR_W-1:0] == SLOT_REG_BASE + CPU_ADDR_W'(i));
    end
  end
  assign strobe.slot_wr = slot_wr;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      mem_ctrl <= MEM_CTRL_RESET;
    end else if (io_wr && mem_ctrl_sel) begin
      mem_ctrl <= i_pwdata;
    end
  end

  assign o_bios_enable = !mem_ctrl[BIOS_DISABLE_BIT];  // Low bit keeps BIOS mapped

  // ==================================================
  // Read mux
  // ==================================================
  assign joy_data = {2'b11, ~i_buttons};  // Pads are active low

  always_comb begin
    o_prdata = 8'hFF;  // PSG, counters and unmapped ports
    if (io_space) begin
      if (vdp_data_sel) o_prdata = i_vdp_rd_data;
      else if (vdp_ctrl_sel) o_prdata = i_status;
      else if (joy_sel) o_prdata = joy_data;
    end
  end

endmodule

//--- design/io_strobe_if.sv
interface io_strobe_if;
  import sms_io_pkg::*;

  logic                 vdp_data_wr;
  logic                 vdp_data_rd;
  logic                 vdp_ctrl_wr;
  logic                 vdp_ctrl_rd;
  logic [NUM_SLOTS-1:0] slot_wr;  // One bit per mapper slot
  logic [DATA_W-1:0]    wdata;

  // Decoder side
  modport source (
    output vdp_data_wr, vdp_data_rd, vdp_ctrl_wr, vdp_ctrl_rd, slot_wr, wdata
  );

  modport vdp_sink (
    input vdp_data_wr, vdp_data_rd, vdp_ctrl_wr, vdp_ctrl_rd, wdata
  );

  modport slot_sink (
    input slot_wr, wdata
  );

endinterface

//--- design/mapper_slot.sv
module mapper_slot #(
  parameter int SLOT_INDEX = 0
) (
  input  logic                              cpuClock,
  input  logic                              n_hard_reset,
  input  logic [sms_io_pkg::CPU_ADDR_W-1:0] i_cpu_addr,
  io_strobe_if.slot_sink                    strobe,
  output logic                              o_hit,
  output logic [sms_io_pkg::ROM_ADDR_W-1:0] o_rom_addr
);
  import sms_io_pkg::*;

  logic [BANK_W-1:0] bank;

  // Power-up mapping is bank n in page n
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      bank <= BANK_W'(SLOT_INDEX);
    end else if (strobe.slot_wr[SLOT_INDEX]) begin
      bank <= strobe.wdata;
    end
  end

  assign o_hit      = i_cpu_addr[CPU_ADDR_W-1:PAGE_W] == PAGE_SEL_W'(SLOT_INDEX);
  assign o_rom_addr = {bank, i_cpu_addr[PAGE_W-1:0]};  // Bank above the page offset

endmodule

//--- design/rom_addr_select.sv
module rom_addr_select (
  input  logic [sms_io_pkg::CPU_ADDR_W-1:0] i_cpu_addr,
  input  logic [sms_io_pkg::NUM_SLOTS-1:0]  i_hit,
  input  logic [sms_io_pkg::ROM_ADDR_W-1:0] i_slot_addr [sms_io_pkg::NUM_SLOTS],
  input  logic                              i_bios_enable,
  output logic [sms_io_pkg::ROM_ADDR_W-1:0] o_rom_addr,
  output logic                              o_bios_sel,
  output logic                              o_ram_sel
);
  import sms_io_pkg::*;

  // Page 3 is work RAM and no slot claims it
  assign o_ram_sel  = &i_cpu_addr[CPU_ADDR_W-1:PAGE_W];
  assign o_bios_sel = !o_ram_sel && i_bios_enable;

  always_comb begin
    o_rom_addr = {{(ROM_ADDR_W-CPU_ADDR_W){1'b0}}, i_cpu_addr};  // Untranslated in RAM page
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (i_hit[s]) begin
        o_rom_addr = i_slot_addr[s];
      end
    end
  end

endmodule

//--- design/sms_io_pkg.sv
package sms_io_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int DATA_W      = 8;
  localparam int CPU_ADDR_W  = 16;
  localparam int APB_ADDR_W  = CPU_ADDR_W + 1;  // Top bit selects I/O space
  localparam int BANK_W      = 8;
  localparam int PAGE_W      = 14;               // 16K pages
  localparam int PAGE_SEL_W  = CPU_ADDR_W - PAGE_W;
  localparam int ROM_ADDR_W  = BANK_W + PAGE_W;
  localparam int VRAM_ADDR_W = 14;
  localparam int MODE_W      = 3;
  localparam int BUTTON_W    = 6;
  localparam int NUM_SLOTS   = 3;

  // ==================================================
  // I/O port codes on address bits 7:6
  // ==================================================
  localparam logic [1:0] PORT_MEM_CTRL = 2'd0;
  localparam logic [1:0] PORT_PSG_VCNT = 2'd1;
  localparam logic [1:0] PORT_VDP_DATA = 2'd2;  // Even address
  localparam logic [1:0] PORT_VDP_CTRL = 2'd2;  // Odd address
  localparam logic [1:0] PORT_JOY      = 2'd3;

  localparam logic [DATA_W-1:0]     MEM_CTRL_RESET   = 8'hF7;
  localparam int                    BIOS_DISABLE_BIT = 3;
  localparam logic [CPU_ADDR_W-1:0] SLOT_REG_BASE    = 16'hFFFD;  // Slot 0, then 1 and 2

  // Second VDP control byte, code in the top two bits
  localparam logic [1:0] CODE_REG_WRITE = 2'd2;
  localparam logic [1:0] CODE_CRAM      = 2'd3;

  typedef struct packed {
    logic [1:0] code;
    logic [5:0] addr_hi;  // VRAM address bits 13:8
  } vdp_addr_view_t;

  typedef struct packed {
    logic [1:0] code;
    logic [1:0] unused;
    logic [3:0] reg_idx;
  } vdp_reg_view_t;

  typedef union packed {
    vdp_addr_view_t addr;
    vdp_reg_view_t  regw;
  } vdp_ctrl_byte_u;

endpackage

//--- design/sms_io_top.sv
module sms_io_top #(
  parameter int NUM_VDP_REGS = 11
) (
  input  logic                               cpuClock,
  input  logic                               n_hard_reset,
  // APB requester side
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic                               i_pwrite,
  input  logic [sms_io_pkg::APB_ADDR_W-1:0]  i_paddr,
  input  logic [sms_io_pkg::DATA_W-1:0]      i_pwdata,
  output logic [sms_io_pkg::DATA_W-1:0]      o_prdata,
  output logic                               o_pready,
  input  logic [sms_io_pkg::BUTTON_W-1:0]    i_buttons,
  input  logic                               i_frame_int,
  input  logic                               i_sprite_collision,
  input  logic [sms_io_pkg::CPU_ADDR_W-1:0]  i_cpu_addr,
  output logic [sms_io_pkg::ROM_ADDR_W-1:0]  o_rom_addr,
  output logic                               o_bios_sel,
  output logic                               o_ram_sel,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                               o_cram_sel,
  output logic [sms_io_pkg::MODE_W-1:0]      o_mode,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_name_table_addr,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_sprite_attr_addr,
  output logic                               o_video_on,
  output logic [sms_io_pkg::DATA_W-1:0]      o_x_scroll,
  output logic [sms_io_pkg::DATA_W-1:0]      o_y_scroll
);
  import sms_io_pkg::*;

  logic [DATA_W-1:0]     status;
  logic [DATA_W-1:0]     vdp_rd_data;
  logic                  bios_enable;
  logic [NUM_SLOTS-1:0]  slot_hit;
  logic [ROM_ADDR_W-1:0] slot_addr [NUM_SLOTS];

  io_strobe_if strobe_bus ();

  apb_io_decoder u_decoder (
    .cpuClock      (cpuClock),
    .n_hard_reset  (n_hard_reset),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready),
    .i_buttons     (i_buttons),
    .i_status      (status),
    .i_vdp_rd_data (vdp_rd_data),
    .o_bios_enable (bios_enable),
    .strobe        (strobe_bus)
  );

  // One mapper slot per ROM page
  for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
    mapper_slot #(.SLOT_INDEX(g)) u_slot (
      .cpuClock     (cpuClock),
      .n_hard_reset (n_hard_reset),
      .i_cpu_addr   (i_cpu_addr),
      .strobe       (strobe_bus),
      .o_hit        (slot_hit[g]),
      .o_rom_addr   (slot_addr[g])
    );
  end

  rom_addr_select u_rom_sel (
    .i_cpu_addr    (i_cpu_addr),
    .i_hit         (slot_hit),
    .i_slot_addr   (slot_addr),
    .i_bios_enable (bios_enable),
    .o_rom_addr    (o_rom_addr),
    .o_bios_sel    (o_bios_sel),
    .o_ram_sel     (o_ram_sel)
  );

  vdp_ctrl_port #(.NUM_VDP_REGS(NUM_VDP_REGS)) u_vdp (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .strobe             (strobe_bus),
    .i_frame_int        (i_frame_int),
    .i_sprite_collision (i_sprite_collision),
    .o_status           (status),
    .o_rd_data          (vdp_rd_data),
    .o_vram_addr        (o_vram_addr),
    .o_cram_sel         (o_cram_sel),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_sprite_attr_addr (o_sprite_attr_addr),
    .o_video_on         (o_video_on),
    .o_x_scroll         (o_x_scroll),
    .o_y_scroll         (o_y_scroll)
  );

endmodule

//--- design/vdp_ctrl_port.sv
module vdp_ctrl_port #(
  parameter int NUM_VDP_REGS = 11
) (
  input  logic                               cpuClock,
  input  logic                               n_hard_reset,
  io_strobe_if.vdp_sink                      strobe,
  input  logic                               i_frame_int,
  input  logic                               i_sprite_collision,
  output logic [sms_io_pkg::DATA_W-1:0]      o_status,
  output logic [sms_io_pkg::DATA_W-1:0]      o_rd_data,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_vram_addr,
  output logic                               o_cram_sel,
  output logic [sms_io_pkg::MODE_W-1:0]      o_mode,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_name_table_addr,
  output logic [sms_io_pkg::VRAM_ADDR_W-1:0] o_sprite_attr_addr,
  output logic                               o_video_on,
  output logic [sms_io_pkg::DATA_W-1:0]      o_x_scroll,
  output logic [sms_io_pkg::DATA_W-1:0]      o_y_scroll
);
  import sms_io_pkg::*;

  logic [DATA_W-1:0]      vdp_regs [NUM_VDP_REGS];
  logic [DATA_W-1:0]      first_byte;
  logic                   second_byte;
  logic [VRAM_ADDR_W-1:0] vram_addr;
  logic                   cram_sel;
  logic                   frame_flag;
  logic                   coll_flag;
  vdp_ctrl_byte_u         ctrl_byte;
  logic                   reg_idx_ok;
  logic                   cram_load;

  // ==================================================
  // Control port byte pairing
  // ==================================================
  assign ctrl_byte  = vdp_ctrl_byte_u'(strobe.wdata);
  assign reg_idx_ok = ctrl_byte.regw.reg_idx < NUM_VDP_REGS;
  // Bad register index falls back to a CRAM address load
  assign cram_load  = (ctrl_byte.addr.code == CODE_CRAM) ||
                      (ctrl_byte.regw.code == CODE_REG_WRITE && !reg_idx_ok);

  always_ff @(posedge cpuClock) begin
    if (strobe.vdp_ctrl_wr && !second_byte) begin
      first_byte <= strobe.wdata;
    end
  end

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_byte <= 1'b0;
      vram_addr   <= '0;
      cram_sel    <= 1'b0;
      for (int r = 0; r < NUM_VDP_REGS; r++) begin
        vdp_regs[r] <= '0;
      end
    end else begin
      if (strobe.vdp_data_wr || strobe.vdp_data_rd) begin
        vram_addr   <= vram_addr + 1'b1;  // Auto-increment
        second_byte <= 1'b0;
      end
      if (strobe.vdp_ctrl_rd) second_byte <= 1'b0;

      if (strobe.vdp_ctrl_wr) begin
        second_byte <= !second_byte;
        if (second_byte) begin
          if (ctrl_byte.addr.code < CODE_REG_WRITE) begin  // VRAM read or write setup
            vram_addr <= {ctrl_byte.addr.addr_hi, first_byte};
            cram_sel  <= 1'b0;
          end else if (cram_load) begin
            vram_addr <= {{(VRAM_ADDR_W-6){1'b0}}, first_byte[5:0]};
            cram_sel  <= 1'b1;
          end else begin
            vdp_regs[ctrl_byte.regw.reg_idx] <= first_byte;
          end
        end
      end
    end
  end

  // ==================================================
  // Status flags, cleared by a status read
  // ==================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      frame_flag <= 1'b0;
      coll_flag  <= 1'b0;
    end else begin
      if (i_frame_int) frame_flag <= 1'b1;
      else if (strobe.vdp_ctrl_rd) frame_flag <= 1'b0;

      if (i_sprite_collision) coll_flag <= 1'b1;
      else if (strobe.vdp_ctrl_rd) coll_flag <= 1'b0;
    end
  end

  assign o_status  = {frame_flag, 1'b0, coll_flag, 5'b11111};
  assign o_rd_data = '0;  // No VRAM behind the data port

  assign o_vram_addr = vram_addr;
  assign o_cram_sel  = cram_sel;

  // Decoded register fields
  assign o_mode = vdp_regs[0][2] ? 3'd4 :
                  vdp_regs[1][3] ? 3'd3 :
                  vdp_regs[0][1] ? 3'd2 :
                  vdp_regs[1][4] ? 3'd1 : 3'd0;

  assign o_name_table_addr  = {vdp_regs[2][3:1], 11'b0};
  assign o_sprite_attr_addr = {vdp_regs[5][6:1], 8'b0};
  assign o_video_on         = vdp_regs[1][6];
  assign o_x_scroll         = vdp_regs[8];
  assign o_y_scroll         = vdp_regs[9];

endmodule

//--- src.f
design/sms_io_pkg.sv
design/io_strobe_if.sv
design/apb_io_decoder.sv
design/mapper_slot.sv
design/rom_addr_select.sv
design/vdp_ctrl_port.sv
design/sms_io_top.sv
bench/sms_io_props.sv
bench/sms_io_tb.sv
